// ==== files.f ====
cpu_pkg.sv
reg_file.sv
decode.sv
execute.sv
data_mem.sv
core_top.sv
tb_clock.sv
tb_top.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_top -f files.f -o sim_tb

out=$(./obj_dir/sim_tb || true)
echo "$out"

if echo "$out" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1

// ==== tb_top.sv ====
`timescale 1ns/100ps

module tb_top;
    localparam logic [26:0] reset_pc   = 27'h100;
    localparam int          prog_words = 1024;
    localparam int          trace_len  = 300;
    localparam int          max_trace  = trace_len + 16; // room for the last template
    localparam logic [31:0] nop_word   = 32'h0;          // add r0, r0, r0

    logic                clk;
    logic                rst;
    logic                run;
    cpu_pkg::inst_word_t inst;
    logic [26:0]         imem_addr;
    cpu_pkg::wb_t        wb;

    logic [31:0] lfsr;
    logic [31:0] prog [prog_words];
    logic [26:0] pc_seq [max_trace];  // fetch address per executed instruction
    logic [6:0]  rec_rd [max_trace];  // expected wb record per instruction
    logic [31:0] rec_val [max_trace];
    logic        rec_mre [max_trace];
    logic [31:0] xreg [32];
    logic [31:0] freg [32];
    logic [31:0] dmem [1024];
    int          last_wr [64];        // indexed by {fp, idx}
    logic        fwd_ok [64];
    logic [26:0] gen_pc;
    int          n_total;

    tb_clock clock_gen (
        .clk (clk),
        .rst (rst)
    );

    core_top #(
        .reset_pc   (reset_pc),
        .dmem_words (1024)
    ) dut (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .inst      (inst),
        .imem_addr (imem_addr),
        .wb        (wb)
    );

    // galois lfsr, one step per bit
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
        end
        return v;
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] fn, input logic [31:0] a,
                                            input logic [31:0] b, input logic sub);
        case (fn)
            3'd0:    return sub ? a - b : a + b;
            3'd1:    return a & b;
            3'd2:    return a | b;
            3'd3:    return a ^ b;
            3'd4:    return a << b[4:0];
            3'd5:    return a >> b[4:0];
            3'd6:    return {31'd0, $signed(a) < $signed(b)};
            default: return {31'd0, a < b};
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] fn, input logic [31:0] a,
                                          input logic [31:0] b);
        case (fn)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd2:    return $signed(a) < $signed(b);
            3'd3:    return $signed(a) >= $signed(b);
            3'd4:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    // directly after a forwardable producer, or three or more behind the writer
    function automatic logic src_ready(input logic [5:0] src);
        int d;
        d = n_total - last_wr[src];
        return src == 6'd0 || d >= 3 || (d == 1 && fwd_ok[src]);
    endfunction

    task automatic report_failure();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
            report_failure();
        end
    endtask

    // place one instruction on the executed path and run it in the model
    task automatic put(input logic [31:0] word, input logic [6:0] wr, input logic [31:0] val,
                       input logic mre, input logic fwd, input logic [26:0] next_pc);
        prog[int'((gen_pc - reset_pc) >> 2)] = word;
        pc_seq[n_total]  = gen_pc;
        rec_rd[n_total]  = wr;
        rec_val[n_total] = val;
        rec_mre[n_total] = mre;
        if (wr[6]) begin
            last_wr[wr[5:0]] = n_total;
            fwd_ok[wr[5:0]]  = fwd;
            if (wr[5])
                freg[wr[4:0]] = val;
            else if (wr[4:0] != 5'd0)
                xreg[wr[4:0]] = val;
        end
        n_total++;
        gen_pc = next_pc;
    endtask

    task automatic clear_hazards(input logic [5:0] s1, input logic [5:0] s2);
        while (!src_ready(s1) || !src_ready(s2)) begin
            put(nop_word, 7'b1000000, 32'd0, 1'b0, 1'b1, gen_pc + 27'd4);
        end
    endtask

    task automatic build_program();
        logic [2:0]  kind;
        logic [2:0]  fn;
        logic [4:0]  ra, rb, rd;
        logic [15:0] imm;
        logic [31:0] simm;
        logic [31:0] ea;
        logic [26:0] target;
        for (int i = 0; i < prog_words; i++) prog[i] = nop_word;
        for (int i = 0; i < 64; i++) begin
            last_wr[i] = -100;
            fwd_ok[i]  = 1'b0;
        end
        for (int i = 0; i < 32; i++) begin
            xreg[i] = '0;
            freg[i] = '0;
        end
        gen_pc  = reset_pc;
        n_total = 0;
        while (n_total < trace_len) begin
            kind = rand_bits(3);
            fn   = rand_bits(3);
            ra   = rand_bits(3);            // r0..r7 keeps dependencies dense
            if (rand_bits(2) == 0)
                rb = ra;
            else
                rb = rand_bits(3);
            rd     = rand_bits(3);
            imm    = rand_bits(16);
            simm   = {{16{imm[15]}}, imm};
            target = gen_pc + (imm[0] ? 27'd12 : 27'd8); // forward skip of one or two words
            case (kind)
                3'd0, 3'd1: begin
                    clear_hazards({1'b0, ra}, {1'b0, rb});
                    put({ra, rd, 10'd0, imm[1], rb, fn, cpu_pkg::op_r}, {2'b10, rd},
                        alu_ref(fn, xreg[ra], xreg[rb], imm[1]), 1'b0, 1'b1, gen_pc + 27'd4);
                end
                3'd2: begin
                    clear_hazards({1'b0, ra}, {1'b0, ra});
                    put({ra, rd, imm, fn, cpu_pkg::op_imm}, {2'b10, rd},
                        alu_ref(fn, xreg[ra], simm, 1'b0), 1'b0, 1'b1, gen_pc + 27'd4);
                end
                3'd3: begin // store, then load back from the same address
                    clear_hazards({1'b0, ra}, {1'b0, rb});
                    ea = xreg[ra] + simm;
                    dmem[ea[11:2]] = xreg[rb];
                    put({ra, imm, rb, 2'b11, fn[0], cpu_pkg::op_sb}, 7'd0, 32'd0, 1'b0, 1'b0,
                        gen_pc + 27'd4);
                    clear_hazards({1'b0, ra}, {1'b0, ra});
                    put({ra, rd, imm, cpu_pkg::mem_load, cpu_pkg::op_mem}, {2'b10, rd},
                        dmem[ea[11:2]], 1'b1, 1'b0, gen_pc + 27'd4);
                end
                3'd4: begin
                    if (fn > 3'd5)
                        fn = fn - 3'd6;
                    clear_hazards({1'b0, ra}, {1'b0, rb});
                    put({ra, 16'(target - gen_pc), rb, fn, cpu_pkg::op_sb}, 7'd0, 32'd0,
                        1'b0, 1'b0,
                        branch_taken(fn, xreg[ra], xreg[rb]) ? target : gen_pc + 27'd4);
                end
                3'd5: begin
                    put({1'b0, target[26:2], 3'b000, cpu_pkg::op_jmp}, 7'd0, 32'd0, 1'b0, 1'b0,
                        target);
                end
                3'd6: begin // int to float, then straight back
                    clear_hazards({1'b0, ra}, {1'b0, ra});
                    put({ra, rd, 16'd0, 3'b100, cpu_pkg::op_fmv}, {2'b11, rd}, xreg[ra],
                        1'b0, 1'b1, gen_pc + 27'd4);
                    clear_hazards({1'b1, rd}, {1'b1, rd});
                    put({rd, rb, 16'd0, 3'b000, cpu_pkg::op_fmv}, {2'b10, rb}, freg[rd],
                        1'b0, 1'b1, gen_pc + 27'd4);
                end
                default: begin
                    put({ra, rd, imm, cpu_pkg::mem_lui, cpu_pkg::op_mem}, {2'b10, rd},
                        {imm, 16'h0000}, 1'b0, 1'b1, gen_pc + 27'd4);
                end
            endcase
        end
    endtask

    function automatic logic [31:0] fetch_word(input logic [26:0] addr);
        logic [26:0] slot;
        slot = (addr - reset_pc) >> 2;
        return slot < prog_words ? prog[slot] : nop_word;
    endfunction

    // fetch address and wb record expected after n running edges
    task automatic compare_stream(input int n);
        if (n < n_total)
            check_value("imem_addr", imem_addr, pc_seq[n]);
        if (n < 3) begin
            check_value("wb.rd.valid", wb.rd.valid, 1'b0);
        end else begin
            check_value("wb.rd.valid", wb.rd.valid, rec_rd[n - 3][6]);
            if (rec_rd[n - 3][6]) begin
                check_value("wb.rd", wb.rd, rec_rd[n - 3]);
                check_value("wb.mre", wb.mre, rec_mre[n - 3]);
                if (rec_mre[n - 3])
                    check_value("wb.memdata", wb.memdata, rec_val[n - 3]);
                else
                    check_value("wb.res", wb.res, rec_val[n - 3]);
            end
        end
    endtask

    initial begin
        int           edges;
        int           pause;
        logic         was_run;
        lfsr = 32'h658d;
        run  = 1'b0;
        inst = nop_word;
        build_program();
        @(negedge rst);
        check_value("imem_addr", imem_addr, reset_pc);
        check_value("wb.rd.valid", wb.rd.valid, 1'b0);
        inst  = fetch_word(imem_addr);
        run   = 1'b1;
        edges = 0;
        pause = 0;
        while (edges < n_total + 2) begin
            was_run = run;
            @(posedge clk);
            #1;
            if (was_run)
                edges++;
            compare_stream(edges); // a frozen pipeline still shows the last record
            if (pause > 0)
                pause--;
            else if (rand_bits(4) == 0)
                pause = 1 + int'(rand_bits(2)); // one to four cycles with run low
            run  = pause == 0;
            inst = fetch_word(imem_addr);
        end
        $display("Done: no errors");
        $finish;
    end

    initial begin
        #((max_trace * 20 + 100) * 10);
        $display("watchdog expired before the instruction stream was fully checked");
        report_failure();
    end

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period
    end

    // released just after the fourth rising edge
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

// ==== core_top.sv ====
`timescale 1ns/100ps

module core_top #(
    parameter logic [26:0] reset_pc   = '0,
    parameter int          dmem_words = 1024
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  run,
    input  cpu_pkg::inst_word_t   inst,
    output logic [26:0]           imem_addr,
    output cpu_pkg::wb_t          wb
);
    cpu_pkg::dec_out_t dec;
    cpu_pkg::ex_out_t  ex;
    logic [31:0]       alu_fwd;

    // fetch, decode, pc
    decode #(
        .reset_pc (reset_pc)
    ) u_decode (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .inst      (inst),
        .imem_addr (imem_addr),
        .alu_fwd   (alu_fwd),
        .wb        (wb),
        .dec       (dec)
    );

    execute u_execute (
        .clk     (clk),
        .rst     (rst),
        .run     (run),
        .dec     (dec),
        .alu_fwd (alu_fwd),
        .ex      (ex)
    );

    // memory and writeback record
    data_mem #(
        .dmem_words (dmem_words)
    ) u_data_mem (
        .clk (clk),
        .rst (rst),
        .run (run),
        .ex  (ex),
        .wb  (wb)
    );

endmodule

// ==== data_mem.sv ====
`timescale 1ns/100ps

module data_mem #(
    parameter int dmem_words = 1024
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               run,
    input  cpu_pkg::ex_out_t   ex,
    output cpu_pkg::wb_t       wb
);
    localparam int aw = $clog2(dmem_words);

    logic [31:0]   mem [dmem_words];
    logic [aw-1:0] widx;

    assign widx = ex.daddr[aw+1:2]; // word address

    always_ff @(posedge clk) begin
        if (run && ex.mwe) begin
            mem[widx] <= ex.store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb <= '0;
        end else if (run) begin
            wb.rd       <= ex.rd;
            wb.rd.valid <= ex.rd.valid && !ex.mwe; // stores write no register
            wb.res      <= ex.res;
            wb.memdata  <= mem[widx];
            wb.mre      <= ex.mre;
        end
    end

endmodule

// ==== execute.sv ====
`timescale 1ns/100ps

module execute (
    input  logic                clk,
    input  logic                rst,
    input  logic                run,
    input  cpu_pkg::dec_out_t   dec,
    output logic [31:0]         alu_fwd,
    output cpu_pkg::ex_out_t    ex
);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] alu_res;
    logic [31:0] res;
    logic        sub;
    logic        is_lui;

    assign a = dec.op1;
    assign b = dec.op2;

    // alt bit only means subtract for register-register ops
    assign sub    = dec.aluctl.alt && dec.aluctl.op == cpu_pkg::op_r;
    assign is_lui = dec.aluctl.op == cpu_pkg::op_mem && dec.aluctl.funct == cpu_pkg::mem_lui;

    always_comb begin
        unique case (dec.aluctl.funct)
            cpu_pkg::fn_add:  alu_res = sub ? a - b : a + b;
            cpu_pkg::fn_and:  alu_res = a & b;
            cpu_pkg::fn_or:   alu_res = a | b;
            cpu_pkg::fn_xor:  alu_res = a ^ b;
            cpu_pkg::fn_sll:  alu_res = a << b[4:0];
            cpu_pkg::fn_srl:  alu_res = a >> b[4:0];
            cpu_pkg::fn_slt:  alu_res = {31'd0, $signed(a) < $signed(b)};
            cpu_pkg::fn_sltu: alu_res = {31'd0, a < b};
        endcase
    end

    always_comb begin
        if (is_lui) begin
            res = {dec.imm[15:0], 16'h0000};
        end else if (dec.aluctl.op == cpu_pkg::op_fmv) begin
            res = a; // move between files
        end else begin
            res = alu_res;
        end
    end

    assign alu_fwd = res;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex <= '0;
        end else if (run) begin
            ex.rd         <= dec.rd;
            ex.res        <= res;
            ex.mre        <= dec.mre;
            ex.mwe        <= dec.mwe;
            ex.daddr      <= dec.daddr;
            ex.store_data <= dec.store_data;
        end
    end

endmodule

// ==== decode.sv ====
`timescale 1ns/100ps

module decode #(
    parameter logic [26:0] reset_pc = '0
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  run,
    input  cpu_pkg::inst_word_t   inst,
    output logic [26:0]           imem_addr,
    input  logic [31:0]           alu_fwd,
    input  cpu_pkg::wb_t          wb,
    output cpu_pkg::dec_out_t     dec
);
    logic [26:0]       pc;
    logic [26:0]       npc;
    logic [26:0]       baddr;
    logic [26:0]       jaddr;
    logic [2:0]        op;
    logic [2:0]        funct;
    logic              rs2_valid;
    logic              fromfreg;
    logic              tofreg;
    cpu_pkg::reg_id_t  rs1;
    cpu_pkg::reg_id_t  rs2;
    cpu_pkg::reg_id_t  rd;
    logic [31:0]       imm_il;
    logic [31:0]       imm_sb;
    logic [31:0]       int_rd1, int_rd2;
    logic [31:0]       flt_rd1, flt_rd2;
    logic [31:0]       src1, src2;
    logic [31:0]       op2;
    logic [31:0]       ea;
    cpu_pkg::wb_t      wb_rf;
    logic              branch;
    logic              jmp;
    logic              less, uless;
    logic              match;

    assign imem_addr = pc;

    assign op    = inst.r_view.opcode;
    assign funct = inst.r_view.funct;

    assign rs2_valid = !op[1] || op == cpu_pkg::op_sb;
    // funct[2] clear moves float to int, set moves int to float
    assign fromfreg  = op == cpu_pkg::op_float || (op == cpu_pkg::op_fmv && !funct[2]);
    assign tofreg    = op == cpu_pkg::op_float || (op == cpu_pkg::op_fmv && funct[2]);

    assign rs1 = '{valid: 1'b1, fp: fromfreg, idx: inst.r_view.rs1};
    assign rs2 = '{valid: rs2_valid, fp: fromfreg, idx: inst.sb_view.rs2};
    assign rd  = '{valid: op[2:1] != 2'b11 && op != cpu_pkg::op_float, // no branch, jump, fpu
                   fp: tofreg, idx: inst.r_view.rd};

    assign imm_il = {{16{inst.i_view.imm16[15]}}, inst.i_view.imm16};
    assign imm_sb = {{16{inst.sb_view.imm16[15]}}, inst.sb_view.imm16};

    // load data folded into the write value
    always_comb begin
        wb_rf = wb;
        if (wb.mre) begin
            wb_rf.res = wb.memdata;
        end
    end

    reg_file #(.hard_zero(1'b1)) int_regs (
        .clk (clk),
        .rst (rst),
        .ra1 ({rs1.fp, rs1.idx}),
        .ra2 ({rs2.fp, rs2.idx}),
        .rd1 (int_rd1),
        .rd2 (int_rd2),
        .wb  (wb_rf),
        .we  (run)
    );

    reg_file #(.hard_zero(1'b0)) float_regs (
        .clk (clk),
        .rst (rst),
        .ra1 ({rs1.fp, rs1.idx}),
        .ra2 ({rs2.fp, rs2.idx}),
        .rd1 (flt_rd1),
        .rd2 (flt_rd2),
        .wb  (wb_rf),
        .we  (run)
    );

    function automatic logic fwd_hit(input cpu_pkg::reg_id_t src,
                                     input cpu_pkg::dec_out_t stage2);
        return src.valid && src == stage2.rd && (src.fp || src.idx != 5'd0) && stage2.alu;
    endfunction

    assign src1 = fwd_hit(rs1, dec) ? alu_fwd : (int_rd1 | flt_rd1);
    assign src2 = fwd_hit(rs2, dec) ? alu_fwd : (int_rd2 | flt_rd2);

    always_comb begin
        case (op)
            cpu_pkg::op_imm,
            cpu_pkg::op_mem,
            cpu_pkg::op_jmp: op2 = imm_il;
            default:         op2 = src2;
        endcase
    end

    assign branch = op == cpu_pkg::op_sb && !(&funct[2:1]); // 11x is a store
    assign jmp    = op == cpu_pkg::op_jmp;

    assign less  = $signed(src1) < $signed(src2);
    assign uless = src1 < src2;

    always_comb begin
        case (funct)
            cpu_pkg::br_eq:  match = src1 == src2;
            cpu_pkg::br_ne:  match = src1 != src2;
            cpu_pkg::br_lt:  match = less;
            cpu_pkg::br_ge:  match = !less;
            cpu_pkg::br_ltu: match = uless;
            cpu_pkg::br_geu: match = !uless;
            default:         match = 1'b0;
        endcase
    end

    assign baddr = pc + imm_sb[26:0];
    assign jaddr = {inst.j_view.target25, 2'b00};

    always_comb begin
        if (branch && match) begin
            npc = baddr;
        end else if (jmp) begin
            npc = jaddr;
        end else begin
            npc = pc + 27'd4;
        end
    end

    assign ea = src1 + (op == cpu_pkg::op_sb ? imm_sb : imm_il);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= reset_pc;
            dec     <= '0;
            dec.alu <= 1'b1;
        end else if (run) begin
            pc             <= npc;
            dec.op1        <= src1;
            dec.op2        <= op2;
            dec.rs1        <= rs1;
            dec.rs2        <= rs2;
            dec.rd         <= rd;
            dec.imm        <= op == cpu_pkg::op_sb ? imm_sb : imm_il;
            dec.aluctl     <= '{alt: inst.r_view.alt, op: op, funct: funct};
            dec.mre        <= op == cpu_pkg::op_mem && funct == cpu_pkg::mem_load;
            dec.mwe        <= op == cpu_pkg::op_sb && funct[2:1] == 2'b11;
            dec.daddr      <= ea[24:0];
            dec.store_data <= src2;
            dec.alu        <= !op[2] || op == cpu_pkg::op_imm // r type, moves, imm
                              || (op == cpu_pkg::op_mem && funct == cpu_pkg::mem_lui);
        end
    end

endmodule

// ==== reg_file.sv ====
`timescale 1ns/100ps

module reg_file #(
    parameter bit hard_zero = 1'b1
) (
    input  logic           clk,
    input  logic           rst,
    input  logic [5:0]     ra1,
    input  logic [5:0]     ra2,
    output logic [31:0]    rd1,
    output logic [31:0]    rd2,
    input  cpu_pkg::wb_t   wb,
    input  logic           we
);
    localparam bit is_float = !hard_zero; // role of this file

    logic [31:0] regs [32];
    logic        wr_en;

    assign wr_en = we && wb.rd.valid && (wb.rd.fp == is_float);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.rd.idx] <= wb.res;
        end
    end

    // the file not addressed returns zero so decode can or both files
    function automatic logic [31:0] read_port(input logic [5:0] ra);
        logic [31:0] data;
        if (ra[5] != is_float) begin
            data = '0;
        end else if (hard_zero && ra[4:0] == 5'd0) begin
            data = '0;
        end else if (wr_en && wb.rd.idx == ra[4:0]) begin
            data = wb.res; // write-through
        end else begin
            data = regs[ra[4:0]];
        end
        return data;
    endfunction

    always_comb begin
        rd1 = read_port(ra1);
        rd2 = read_port(ra2);
    end

endmodule

// ==== cpu_pkg.sv ====
package cpu_pkg;

    // opcodes, bits 2..0
    localparam logic [2:0] op_r     = 3'b000;
    localparam logic [2:0] op_float = 3'b010;
    localparam logic [2:0] op_fmv   = 3'b011;
    localparam logic [2:0] op_imm   = 3'b100;
    localparam logic [2:0] op_mem   = 3'b101;
    localparam logic [2:0] op_sb    = 3'b110;
    localparam logic [2:0] op_jmp   = 3'b111;

    // alu function codes, bits 5..3
    localparam logic [2:0] fn_add  = 3'b000; // sub with alt bit
    localparam logic [2:0] fn_and  = 3'b001;
    localparam logic [2:0] fn_or   = 3'b010;
    localparam logic [2:0] fn_xor  = 3'b011;
    localparam logic [2:0] fn_sll  = 3'b100;
    localparam logic [2:0] fn_srl  = 3'b101;
    localparam logic [2:0] fn_slt  = 3'b110;
    localparam logic [2:0] fn_sltu = 3'b111;

    // function codes under op_mem
    localparam logic [2:0] mem_load = 3'b000;
    localparam logic [2:0] mem_lui  = 3'b010;

    // branch conditions under op_sb, 11x are stores
    localparam logic [2:0] br_eq  = 3'b000;
    localparam logic [2:0] br_ne  = 3'b001;
    localparam logic [2:0] br_lt  = 3'b010;
    localparam logic [2:0] br_ge  = 3'b011;
    localparam logic [2:0] br_ltu = 3'b100;
    localparam logic [2:0] br_geu = 3'b101;

    typedef union packed {
        struct packed {
            logic [4:0] rs1;
            logic [4:0] rd;
            logic [9:0] gap;
            logic       alt;    // sub instead of add
            logic [4:0] rs2;
            logic [2:0] funct;
            logic [2:0] opcode;
        } r_view;
        struct packed {
            logic [4:0]  rs1;
            logic [4:0]  rd;
            logic [15:0] imm16;
            logic [2:0]  funct;
            logic [2:0]  opcode;
        } i_view;
        struct packed {
            logic [4:0]  rs1;
            logic [15:0] imm16; // bits 26..11
            logic [4:0]  rs2;
            logic [2:0]  funct;
            logic [2:0]  opcode;
        } sb_view;
        struct packed {
            logic        spare;
            logic [24:0] target25; // word address of jump
            logic [2:0]  funct;
            logic [2:0]  opcode;
        } j_view;
    } inst_word_t;

    typedef struct packed {
        logic       valid;
        logic       fp;     // float register file
        logic [4:0] idx;
    } reg_id_t;

    typedef struct packed {
        logic       alt;
        logic [2:0] op;
        logic [2:0] funct;
    } alu_ctl_t;

    typedef struct packed {
        logic [31:0] op1;
        logic [31:0] op2;
        reg_id_t     rs1;
        reg_id_t     rs2;
        reg_id_t     rd;
        logic [31:0] imm;
        alu_ctl_t    aluctl;
        logic        mre;
        logic        mwe;
        logic [24:0] daddr;
        logic [31:0] store_data;
        logic        alu;   // result can be forwarded
    } dec_out_t;

    typedef struct packed {
        reg_id_t     rd;
        logic [31:0] res;
        logic        mre;
        logic        mwe;
        logic [24:0] daddr;
        logic [31:0] store_data;
    } ex_out_t;

    typedef struct packed {
        reg_id_t     rd;
        logic [31:0] res;
        logic [31:0] memdata;
        logic        mre;
    } wb_t;

endpackage
